/* filelist.f */
cpu_pkg.sv
cpu_fetch.sv
cpu_control.sv
cpu_regfile.sv
cpu_alu.sv
cpu_data_mem.sv
cpu.sv
tb_clock.sv
cpu_asserts.sv
cpu_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module cpu_tb \
	-f filelist.f \
	-o sim_cpu

./obj_dir/sim_cpu > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
exit 0

/* cpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

	localparam int IMEM_WORDS = 256;
	localparam int DMEM_WORDS = 256;
	localparam int IMEM_AW    = 8;
	localparam int DMEM_AW    = 8;
	localparam int PROG_MAX   = 32; // Longest program in words
	// Retired instructions per test with both reload programs counted
	localparam int RUN_TOTAL  = 24 + 16 + 24 + 26 + 10 + 5 + 8;
	localparam int LIMIT      = 2 * (RUN_TOTAL + 7 * (PROG_MAX + 1));

	logic             clk;
	logic             reset;
	logic             imem_load_en;
	logic [7:0]       imem_load_addr;
	logic [31:0]      imem_load_data;
	cpu_pkg::retire_t retire;

	// Reference model state
	logic [31:0] m_pc;
	logic [31:0] m_regs [32];
	logic [31:0] m_mem [DMEM_WORDS];
	logic [31:0] m_imem [IMEM_WORDS];

	logic [31:0] prog [$];
	integer      seed;
	int          errors;
	int          checks;
	int          tests;
	int          retired;
	int          cycles;

	tb_clock u_clock (
		.clk(clk)
	);

	cpu #(
		.IMEM_WORDS(IMEM_WORDS),
		.DMEM_WORDS(DMEM_WORDS)
	) dut (
		.clk           (clk),
		.reset         (reset),
		.imem_load_en  (imem_load_en),
		.imem_load_addr(imem_load_addr),
		.imem_load_data(imem_load_data),
		.retire        (retire)
	);

	function automatic logic [31:0] r_type(input logic [5:0] fn, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt);
		return {6'h00, rs, rt, rd, 5'h00, fn};
	endfunction

	function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rt,
		input logic [4:0] rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] rand_word();
		return $random(seed);
	endfunction

	task automatic emit(input logic [31:0] word);
		prog.push_back(word);
	endtask

	// Full 32-bit constant in two instructions
	task automatic set_const(input logic [4:0] r, input logic [31:0] v);
		emit(i_type(cpu_pkg::OP_LUI, r, 5'd0, v[31:16]));
		emit(i_type(cpu_pkg::OP_ORI, r, r, v[15:0]));
	endtask

	task automatic jump_self();
		emit({cpu_pkg::OP_J, 26'(prog.size())});
	endtask

	// ISA-level model of one instruction that also updates the model state
	function automatic cpu_pkg::retire_t exec_ref(inout logic [31:0] pc,
		input logic [31:0] ins);
		cpu_pkg::retire_t r;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] simm;
		logic [31:0] addr;
		logic [31:0] npc;
		a    = m_regs[ins[25:21]];
		b    = m_regs[ins[20:16]];
		simm = {{16{ins[15]}}, ins[15:0]};
		addr = a + simm;
		npc  = pc + 32'd4;
		r    = '0;
		r.valid   = 1'b1;
		r.pc      = pc;
		r.instr   = ins;
		r.wr_en   = 1'b1;
		r.wr_addr = ins[20:16]; // rt unless R-type
		case (ins[31:26])
			cpu_pkg::OP_RTYPE: begin
				r.wr_addr = ins[15:11];
				case (ins[5:0])
					cpu_pkg::FN_ADDU: r.wr_data = a + b;
					cpu_pkg::FN_SUBU: r.wr_data = a - b;
					cpu_pkg::FN_AND:  r.wr_data = a & b;
					cpu_pkg::FN_OR:   r.wr_data = a | b;
					cpu_pkg::FN_SLT:  r.wr_data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default: begin
						r.wr_en   = 1'b0;
						r.invalid = 1'b1;
					end
				endcase
			end
			cpu_pkg::OP_ADDIU: r.wr_data = a + simm;
			cpu_pkg::OP_ORI:   r.wr_data = a | {16'h0000, ins[15:0]};
			cpu_pkg::OP_LUI:   r.wr_data = {ins[15:0], 16'h0000};
			cpu_pkg::OP_LW:    r.wr_data = m_mem[addr[DMEM_AW+1:2]];
			cpu_pkg::OP_SW: begin
				r.wr_en     = 1'b0;
				r.mem_wr_en = 1'b1;
				m_mem[addr[DMEM_AW+1:2]] = b;
			end
			cpu_pkg::OP_BEQ: begin
				r.wr_en = 1'b0;
				if (a == b)
					npc = pc + 32'd4 + (simm << 2);
			end
			cpu_pkg::OP_BNE: begin
				r.wr_en = 1'b0;
				if (a != b)
					npc = pc + 32'd4 + (simm << 2);
			end
			cpu_pkg::OP_J: begin
				r.wr_en = 1'b0;
				npc = {pc[31:28], ins[25:0], 2'b00};
			end
			default: begin
				r.wr_en   = 1'b0;
				r.invalid = 1'b1;
			end
		endcase
		if (r.wr_en && r.wr_addr != 5'd0)
			m_regs[r.wr_addr] = r.wr_data;
		pc = npc;
		return r;
	endfunction

	task automatic check_hex(input string name, input logic [31:0] exp_val,
		input logic [31:0] got_val);
		checks++;
		assert (got_val === exp_val) else begin
			$display("ERR %s expected %h got %h at pc %h", name, exp_val, got_val, retire.pc);
			errors++;
		end
	endtask

	// Compare the retire record with the model on every edge
	always @(posedge clk) begin
		cpu_pkg::retire_t expected;
		check_hex("valid", {31'b0, ~reset}, {31'b0, retire.valid});
		if (retire.valid) begin
			expected = exec_ref(m_pc, m_imem[m_pc[IMEM_AW+1:2]]);
			check_hex("pc", expected.pc, retire.pc);
			check_hex("instr", expected.instr, retire.instr);
			check_hex("wr_en", {31'b0, expected.wr_en}, {31'b0, retire.wr_en});
			check_hex("mem_wr_en", {31'b0, expected.mem_wr_en}, {31'b0, retire.mem_wr_en});
			check_hex("invalid", {31'b0, expected.invalid}, {31'b0, retire.invalid});
			if (expected.wr_en) begin
				check_hex("wr_addr", {27'b0, expected.wr_addr}, {27'b0, retire.wr_addr});
				check_hex("wr_data", expected.wr_data, retire.wr_data);
			end
			retired++;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("Run stopped after %0d cycles, the tests did not finish in time", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	// Holds reset for at least 4 cycles while the program goes in
	task automatic load_program();
		int n;
		int load_cycles;
		n = prog.size();
		load_cycles = (n > 4) ? n : 4;
		@(negedge clk);
		reset = 1'b1;
		for (int i = 0; i < load_cycles; i++) begin
			imem_load_en   = (i < n);
			imem_load_addr = 8'(i);
			imem_load_data = (i < n) ? prog[i] : 32'h0;
			if (i < n)
				m_imem[i] = prog[i];
			@(negedge clk);
		end
		imem_load_en = 1'b0;
		m_pc = '0;
		for (int r = 0; r < 32; r++)
			m_regs[r] = '0;
		for (int w = 0; w < DMEM_WORDS; w++)
			m_mem[w] = '0;
		retired = 0;
		reset = 1'b0;
	endtask

	task automatic wait_retired(input int n);
		while (retired < n)
			@(negedge clk);
	endtask

	task automatic run_program(input string name, input int n);
		int err_start;
		err_start = errors;
		load_program();
		wait_retired(n);
		tests++;
		$display("%s: %0d retired, %0d errors", name, n, errors - err_start);
	endtask

	task automatic alu_ops();
		prog.delete();
		set_const(5'd1, rand_word());
		set_const(5'd2, rand_word() | 32'h8000_0000); // Negative
		set_const(5'd3, rand_word() & 32'h7fff_ffff); // Positive
		emit(r_type(cpu_pkg::FN_ADDU, 5'd4, 5'd1, 5'd2));
		emit(r_type(cpu_pkg::FN_SUBU, 5'd5, 5'd1, 5'd2));
		emit(r_type(cpu_pkg::FN_AND, 5'd6, 5'd1, 5'd3));
		emit(r_type(cpu_pkg::FN_OR, 5'd7, 5'd2, 5'd3));
		emit(r_type(cpu_pkg::FN_SLT, 5'd8, 5'd2, 5'd3));
		emit(r_type(cpu_pkg::FN_SLT, 5'd9, 5'd3, 5'd2));
		emit(r_type(cpu_pkg::FN_SLT, 5'd10, 5'd1, 5'd2));
		emit(i_type(cpu_pkg::OP_ADDIU, 5'd11, 5'd1, 16'(rand_word()) & 16'h7fff));
		emit(i_type(cpu_pkg::OP_ADDIU, 5'd12, 5'd2, 16'(rand_word()) | 16'h8000));
		emit(r_type(cpu_pkg::FN_ADDU, 5'd0, 5'd1, 5'd2)); // Lost write to r0
		emit(r_type(cpu_pkg::FN_OR, 5'd13, 5'd0, 5'd1));
		jump_self();
		run_program("alu ops", 24);
	endtask

	task automatic constants();
		prog.delete();
		emit(i_type(cpu_pkg::OP_LUI, 5'd1, 5'd0, 16'h1234));
		emit(i_type(cpu_pkg::OP_ORI, 5'd2, 5'd0, 16'hffff)); // Zero extended
		emit(i_type(cpu_pkg::OP_ORI, 5'd3, 5'd1, 16'h8001));
		set_const(5'd4, rand_word());
		set_const(5'd5, rand_word());
		set_const(5'd6, 32'hffff_ffff);
		emit(r_type(cpu_pkg::FN_OR, 5'd7, 5'd4, 5'd0));
		jump_self();
		run_program("constants", 16);
	endtask

	task automatic memory_roundtrip();
		logic [15:0] offs [4];
		logic [31:0] rnd;
		prog.delete();
		emit(i_type(cpu_pkg::OP_ADDIU, 5'd1, 5'd0, 16'h0100)); // Base address
		for (int k = 0; k < 4; k++) begin
			rnd = rand_word();
			offs[k] = 16'(k * 16) | {12'h000, rnd[1:0], 2'b00};
			set_const(5'd2, rand_word());
			emit(i_type(cpu_pkg::OP_SW, 5'd2, 5'd1, offs[k]));
		end
		for (int k = 0; k < 4; k++)
			emit(i_type(cpu_pkg::OP_LW, 5'(10 + k), 5'd1, offs[k]));
		emit(i_type(cpu_pkg::OP_LW, 5'd20, 5'd0, 16'h0040)); // Never stored
		emit(i_type(cpu_pkg::OP_SW, 5'd2, 5'd1, 16'hfffc));
		emit(i_type(cpu_pkg::OP_LW, 5'd21, 5'd1, 16'hfffc));
		jump_self();
		run_program("memory", 24);
	endtask

	task automatic branches();
		prog.delete();
		emit(i_type(cpu_pkg::OP_ADDIU, 5'd1, 5'd0, 16'd5));
		emit(i_type(cpu_pkg::OP_ADDIU, 5'd2, 5'd0, 16'd5));
		emit(i_type(cpu_pkg::OP_ADDIU, 5'd3, 5'd0, 16'd7));
		emit(i_type(cpu_pkg::OP_BEQ, 5'd2, 5'd1, 16'd2)); // Taken to index 6
		emit(i_type(cpu_pkg::OP_ADDIU, 5'd10, 5'd0, 16'd1));
		emit(i_type(cpu_pkg::OP_ADDIU, 5'd10, 5'd0, 16'd2));
		emit(i_type(cpu_pkg::OP_BNE, 5'd2, 5'd1, 16'd1)); // Not taken
		emit(i_type(cpu_pkg::OP_BEQ, 5'd3, 5'd1, 16'd1)); // Not taken
		emit(i_type(cpu_pkg::OP_ADDIU, 5'd4, 5'd4, 16'd1));
		emit(i_type(cpu_pkg::OP_BNE, 5'd3, 5'd4, 16'hfffe)); // Loop back to 8
		emit({cpu_pkg::OP_J, 26'd12});
		emit(i_type(cpu_pkg::OP_ADDIU, 5'd11, 5'd0, 16'd9));
		jump_self();
		run_program("branches and jumps", 26);
	endtask

	task automatic invalid_ops();
		logic [31:0] w;
		prog.delete();
		w = rand_word();
		emit(i_type(cpu_pkg::OP_ADDIU, 5'd1, 5'd0, 16'd3));
		emit({6'h3f, w[25:0]});
		emit(r_type(6'h00, 5'd5, 5'd1, 5'd1)); // Shift is not in the subset
		emit(i_type(6'h08, 5'd1, 5'd1, 16'h0010));
		emit(i_type(cpu_pkg::OP_ADDIU, 5'd2, 5'd1, 16'd1));
		jump_self();
		run_program("invalid encodings", 10);
	endtask

	task automatic reset_reload();
		int err_start;
		err_start = errors;
		prog.delete();
		emit(i_type(cpu_pkg::OP_ADDIU, 5'd1, 5'd0, 16'h0055));
		emit(i_type(cpu_pkg::OP_SW, 5'd1, 5'd0, 16'h0000));
		for (int k = 0; k < 8; k++)
			emit(i_type(cpu_pkg::OP_ADDIU, 5'd1, 5'd1, 16'd1));
		jump_self();
		load_program();
		wait_retired(5); // Stop mid-program
		prog.delete();
		emit(r_type(cpu_pkg::FN_OR, 5'd2, 5'd1, 5'd0));
		emit(i_type(cpu_pkg::OP_LW, 5'd3, 5'd0, 16'h0000));
		emit(r_type(cpu_pkg::FN_ADDU, 5'd4, 5'd1, 5'd1));
		jump_self();
		load_program();
		wait_retired(8);
		tests++;
		$display("reset and reload: 13 retired, %0d errors", errors - err_start);
	endtask

	initial begin
		seed           = 45714;
		reset          = 1'b1;
		imem_load_en   = 1'b0;
		imem_load_addr = '0;
		imem_load_data = '0;
		errors         = 0;
		checks         = 0;
		tests          = 0;
		retired        = 0;
		cycles         = 0;
		m_pc           = '0;
		alu_ops();
		constants();
		memory_roundtrip();
		branches();
		invalid_ops();
		reset_reload();
		$display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* cpu_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_asserts (
	input wire logic        clk,
	input wire logic        reset,
	input cpu_pkg::retire_t retire
);

	// Nothing retires while the core is held
	valid_low_in_reset: assert property (@(posedge clk) reset |-> !retire.valid)
		else $error("retire record valid while reset is high");

	// An unknown encoding must behave as a no-op
	invalid_no_write: assert property (@(posedge clk)
		retire.invalid |-> (!retire.wr_en && !retire.mem_wr_en))
		else $error("invalid instruction wrote a register or memory");

	pc_word_aligned: assert property (@(posedge clk) retire.pc[1:0] == 2'b00)
		else $error("program counter not word aligned");

endmodule

bind cpu cpu_asserts u_asserts (
	.clk   (clk),
	.reset (reset),
	.retire(retire)
);

`default_nettype wire

/* tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter real PERIOD_NS = 8.0
) (
	output logic clk
);

	initial clk = 1'b0;

	always #(PERIOD_NS / 2.0) clk = ~clk; // 8 ns period

endmodule

`default_nettype wire

/* cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu #(
	parameter int IMEM_WORDS = 256,
	parameter int DMEM_WORDS = 256
) (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          imem_load_en,
	input  logic [$clog2(IMEM_WORDS)-1:0] imem_load_addr,
	input  logic [cpu_pkg::XLEN-1:0]      imem_load_data,
	output cpu_pkg::retire_t              retire
);

	logic [cpu_pkg::XLEN-1:0] pc;
	logic [cpu_pkg::XLEN-1:0] instr;
	cpu_pkg::ctrl_t           ctrl;
	logic [cpu_pkg::XLEN-1:0] rs_data;
	logic [cpu_pkg::XLEN-1:0] rt_data;
	logic [cpu_pkg::XLEN-1:0] imm_ext;
	logic [cpu_pkg::XLEN-1:0] alu_b;
	logic [cpu_pkg::XLEN-1:0] alu_result;
	logic                     equal;
	logic [cpu_pkg::XLEN-1:0] load_data;
	logic [4:0]               wr_addr;
	logic [cpu_pkg::XLEN-1:0] wr_data;

	cpu_fetch #(
		.IMEM_WORDS(IMEM_WORDS)
	) u_fetch (
		.clk          (clk),
		.reset        (reset),
		.load_en      (imem_load_en),
		.load_addr    (imem_load_addr),
		.load_data    (imem_load_data),
		.npc_mode     (ctrl.npc_mode),
		.equal        (equal),
		.branch_offset(imm_ext),
		.pc           (pc),
		.instr        (instr)
	);

	cpu_control u_control (
		.instr(instr),
		.ctrl (ctrl)
	);

	// Immediate extension
	always_comb begin
		case (ctrl.ext_mode)
			cpu_pkg::EXT_ZERO:  imm_ext = {16'h0000, instr[15:0]};
			default:            imm_ext = {{16{instr[15]}}, instr[15:0]};
		endcase
	end

	assign wr_addr = ctrl.wr_addr_rd ? instr[15:11] : instr[20:16]; // rd or rt
	assign alu_b   = ctrl.alu_src_imm ? imm_ext : rt_data;
	assign wr_data = ctrl.wb_from_mem ? load_data : alu_result;

	cpu_regfile u_regfile (
		.clk    (clk),
		.reset  (reset),
		.rs_addr(instr[25:21]),
		.rt_addr(instr[20:16]),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.wr_en  (ctrl.reg_wr),
		.rs_data(rs_data),
		.rt_data(rt_data)
	);

	cpu_alu u_alu (
		.a     (rs_data),
		.b     (alu_b),
		.op    (ctrl.alu_op),
		.result(alu_result),
		.equal (equal)
	);

	cpu_data_mem #(
		.DMEM_WORDS(DMEM_WORDS)
	) u_data_mem (
		.clk    (clk),
		.reset  (reset),
		.addr   (alu_result),
		.wr_data(rt_data), // Store data from rt
		.wr_en  (ctrl.mem_wr),
		.rd_data(load_data)
	);

	// Same-cycle view of the executing instruction
	assign retire.valid     = ~reset;
	assign retire.pc        = pc;
	assign retire.instr     = instr;
	assign retire.wr_en     = ctrl.reg_wr;
	assign retire.wr_addr   = wr_addr;
	assign retire.wr_data   = wr_data;
	assign retire.mem_wr_en = ctrl.mem_wr;
	assign retire.invalid   = ctrl.invalid;

endmodule

`default_nettype wire

/* cpu_data_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_data_mem #(
	parameter int DMEM_WORDS = 256
) (
	input  logic                     clk,
	input  logic                     reset,
	input  logic [cpu_pkg::XLEN-1:0] addr,
	input  logic [cpu_pkg::XLEN-1:0] wr_data,
	input  logic                     wr_en,
	output logic [cpu_pkg::XLEN-1:0] rd_data
);

	localparam int DMEM_AW = $clog2(DMEM_WORDS);

	logic [cpu_pkg::XLEN-1:0] mem [DMEM_WORDS];
	logic [DMEM_AW-1:0]       word_idx;

	assign word_idx = addr[DMEM_AW+1:2]; // Byte offset dropped, wraps

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < DMEM_WORDS; i++)
				mem[i] <= '0;
		end else if (wr_en) begin
			mem[word_idx] <= wr_data;
		end
	end

	assign rd_data = mem[word_idx];

endmodule

`default_nettype wire

/* cpu_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_alu (
	input  logic [cpu_pkg::XLEN-1:0] a,
	input  logic [cpu_pkg::XLEN-1:0] b,
	input  cpu_pkg::alu_op_e         op,
	output logic [cpu_pkg::XLEN-1:0] result,
	output logic                     equal
);

	logic [cpu_pkg::XLEN-1:0] diff;
	logic                     less;

	assign diff = a - b;

	// Signed compare from the subtraction and operand signs
	assign less = (a[cpu_pkg::XLEN-1] != b[cpu_pkg::XLEN-1]) ?
		a[cpu_pkg::XLEN-1] : diff[cpu_pkg::XLEN-1];

	always_comb begin
		case (op)
			cpu_pkg::ALU_ADD: result = a + b;
			cpu_pkg::ALU_SUB: result = diff;
			cpu_pkg::ALU_AND: result = a & b;
			cpu_pkg::ALU_OR:  result = a | b;
			cpu_pkg::ALU_SLT: result = {{(cpu_pkg::XLEN-1){1'b0}}, less};
			cpu_pkg::ALU_LUI: result = {b[15:0], 16'h0000};
			default:          result = '0;
		endcase
	end

	assign equal = (a == b); // Branch condition

endmodule

`default_nettype wire

/* cpu_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_regfile (
	input  logic                     clk,
	input  logic                     reset,
	input  logic [4:0]               rs_addr,
	input  logic [4:0]               rt_addr,
	input  logic [4:0]               wr_addr,
	input  logic [cpu_pkg::XLEN-1:0] wr_data,
	input  logic                     wr_en,
	output logic [cpu_pkg::XLEN-1:0] rs_data,
	output logic [cpu_pkg::XLEN-1:0] rt_data
);

	logic [cpu_pkg::XLEN-1:0] regs [32];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wr_en && (wr_addr != 5'd0)) begin
			regs[wr_addr] <= wr_data; // Register 0 never written
		end
	end

	// No bypass, a write shows up for the next instruction
	assign rs_data = (rs_addr == 5'd0) ? '0 : regs[rs_addr];
	assign rt_data = (rt_addr == 5'd0) ? '0 : regs[rt_addr];

endmodule

`default_nettype wire

/* cpu_control.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_control (
	input  logic [cpu_pkg::XLEN-1:0] instr,
	output cpu_pkg::ctrl_t           ctrl
);

	cpu_pkg::opcode_e opcode;
	cpu_pkg::funct_e  funct;

	assign opcode = cpu_pkg::opcode_e'(instr[31:26]);
	assign funct  = cpu_pkg::funct_e'(instr[5:0]);

	always_comb begin
		// Defaults describe a no-op
		ctrl.alu_op      = cpu_pkg::ALU_ADD;
		ctrl.alu_src_imm = 1'b0;
		ctrl.wr_addr_rd  = 1'b0;
		ctrl.wb_from_mem = 1'b0;
		ctrl.reg_wr      = 1'b0;
		ctrl.mem_wr      = 1'b0;
		ctrl.ext_mode    = cpu_pkg::EXT_SIGN;
		ctrl.npc_mode    = cpu_pkg::NPC_SEQ;
		ctrl.invalid     = 1'b0;

		case (opcode)
			cpu_pkg::OP_RTYPE: begin
				ctrl.wr_addr_rd = 1'b1;
				ctrl.reg_wr     = 1'b1;
				case (funct)
					cpu_pkg::FN_ADDU: ctrl.alu_op = cpu_pkg::ALU_ADD;
					cpu_pkg::FN_SUBU: ctrl.alu_op = cpu_pkg::ALU_SUB;
					cpu_pkg::FN_AND:  ctrl.alu_op = cpu_pkg::ALU_AND;
					cpu_pkg::FN_OR:   ctrl.alu_op = cpu_pkg::ALU_OR;
					cpu_pkg::FN_SLT:  ctrl.alu_op = cpu_pkg::ALU_SLT;
					default: begin
						ctrl.reg_wr  = 1'b0; // Unknown funct
						ctrl.invalid = 1'b1;
					end
				endcase
			end
			cpu_pkg::OP_ADDIU: begin
				ctrl.alu_src_imm = 1'b1;
				ctrl.reg_wr      = 1'b1;
			end
			cpu_pkg::OP_ORI: begin
				ctrl.alu_op      = cpu_pkg::ALU_OR;
				ctrl.alu_src_imm = 1'b1;
				ctrl.ext_mode    = cpu_pkg::EXT_ZERO;
				ctrl.reg_wr      = 1'b1;
			end
			cpu_pkg::OP_LUI: begin
				ctrl.alu_op      = cpu_pkg::ALU_LUI;
				ctrl.alu_src_imm = 1'b1;
				ctrl.ext_mode    = cpu_pkg::EXT_ZERO;
				ctrl.reg_wr      = 1'b1;
			end
			cpu_pkg::OP_LW: begin
				ctrl.alu_src_imm = 1'b1; // Base plus offset
				ctrl.wb_from_mem = 1'b1;
				ctrl.reg_wr      = 1'b1;
			end
			cpu_pkg::OP_SW: begin
				ctrl.alu_src_imm = 1'b1;
				ctrl.mem_wr      = 1'b1;
			end
			cpu_pkg::OP_BEQ: ctrl.npc_mode = cpu_pkg::NPC_BRANCH_EQ;
			cpu_pkg::OP_BNE: ctrl.npc_mode = cpu_pkg::NPC_BRANCH_NE;
			cpu_pkg::OP_J:   ctrl.npc_mode = cpu_pkg::NPC_JUMP;
			default:         ctrl.invalid  = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

/* cpu_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_fetch #(
	parameter int IMEM_WORDS = 256
) (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          load_en,
	input  logic [$clog2(IMEM_WORDS)-1:0] load_addr,
	input  logic [cpu_pkg::XLEN-1:0]      load_data,
	input  cpu_pkg::npc_mode_e            npc_mode,
	input  logic                          equal,
	input  logic [cpu_pkg::XLEN-1:0]      branch_offset,
	output logic [cpu_pkg::XLEN-1:0]      pc,
	output logic [cpu_pkg::XLEN-1:0]      instr
);

	localparam int IMEM_AW = $clog2(IMEM_WORDS);

	logic [cpu_pkg::XLEN-1:0] imem [IMEM_WORDS];
	logic [cpu_pkg::XLEN-1:0] pc_plus4;
	logic [cpu_pkg::XLEN-1:0] branch_target;
	logic [cpu_pkg::XLEN-1:0] next_pc;

	// Program load only while the core is held in reset
	always_ff @(posedge clk) begin
		if (reset && load_en)
			imem[load_addr] <= load_data;
	end

	assign instr = imem[pc[IMEM_AW+1:2]]; // Wraps at IMEM_WORDS

	assign pc_plus4      = pc + 32'd4;
	assign branch_target = pc_plus4 + {branch_offset[cpu_pkg::XLEN-3:0], 2'b00};

	always_comb begin
		unique case (npc_mode)
			cpu_pkg::NPC_BRANCH_EQ: next_pc = equal ? branch_target : pc_plus4;
			cpu_pkg::NPC_BRANCH_NE: next_pc = equal ? pc_plus4 : branch_target;
			cpu_pkg::NPC_JUMP:      next_pc = {pc[31:28], instr[25:0], 2'b00};
			default:                next_pc = pc_plus4;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			pc <= '0;
		else
			pc <= next_pc;
	end

endmodule

`default_nettype wire

/* cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	localparam int XLEN = 32; // Data word width

	// Primary opcode field, instr[31:26]
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_J     = 6'h02,
		OP_BEQ   = 6'h04,
		OP_BNE   = 6'h05,
		OP_ADDIU = 6'h09,
		OP_ORI   = 6'h0d,
		OP_LUI   = 6'h0f,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b
	} opcode_e;

	// R-type function field, instr[5:0]
	typedef enum logic [5:0] {
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_SLT  = 6'h2a
	} funct_e;

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_SLT = 3'd4,
		ALU_LUI = 3'd5 // b[15:0] into upper half
	} alu_op_e;

	typedef enum logic [1:0] {
		EXT_SIGN  = 2'd0,
		EXT_ZERO  = 2'd1,
		EXT_UPPER = 2'd2
	} ext_mode_e;

	typedef enum logic [1:0] {
		NPC_SEQ       = 2'd0,
		NPC_BRANCH_EQ = 2'd1,
		NPC_BRANCH_NE = 2'd2,
		NPC_JUMP      = 2'd3
	} npc_mode_e;

	// Control word from the decoder
	typedef struct packed {
		alu_op_e   alu_op;
		logic      alu_src_imm; // Second operand from immediate
		logic      wr_addr_rd;  // Write to rd, else rt
		logic      wb_from_mem; // Write back load data
		logic      reg_wr;
		logic      mem_wr;
		ext_mode_e ext_mode;
		npc_mode_e npc_mode;
		logic      invalid;
	} ctrl_t;

	// One record per retired instruction
	typedef struct packed {
		logic            valid;
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] instr;
		logic            wr_en;
		logic [4:0]      wr_addr;
		logic [XLEN-1:0] wr_data;
		logic            mem_wr_en;
		logic            invalid;
	} retire_t;

endpackage

`default_nettype wire
